// ==== rtl/periph_bus_pkg.sv ====
// Peripheral bus package
// Shared widths, APB region map, interrupt counts and the enums used by
// the AHB-lite to APB bridge and the interrupt collector

`default_nettype none

package periph_bus_pkg;

	//==========================================================================
	// System bus
	//==========================================================================

	localparam int ADDR_W = 32;                     // System address width
	localparam int DATA_W = 32;                     // Bus data width

	typedef logic [ADDR_W-1:0] sys_addr_t;
	typedef logic [DATA_W-1:0] sys_data_t;

	// AHB transfer type encoding
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	//==========================================================================
	// APB region map
	//==========================================================================

	localparam int        N_APB_REGIONS   = 3;            // APB0..APB2
	localparam sys_addr_t APB_BASE        = 32'h4000_0000; // Region 0 base
	localparam int        APB_REGION_LOG2 = 16;           // 64 KB per region

	typedef logic [1:0]               apb_region_t; // Region index
	typedef logic [N_APB_REGIONS-1:0] apb_sel_t;    // One-hot psel

	// Bridge sequencing
	typedef enum logic [1:0] {
		ST_IDLE,    // Address phase, ready high
		ST_LATCH,   // Write data sampled
		ST_SETUP,   // APB setup phase
		ST_ACCESS   // APB access, wait on pready
	} bridge_state_e;

	//==========================================================================
	// Interrupts
	//==========================================================================

	localparam int N_SYNC_IRQ      = 8;                      // Already on sys clock
	localparam int N_ASYNC_IRQ     = 16;                     // Need resync
	localparam int N_IRQ           = N_SYNC_IRQ + N_ASYNC_IRQ;
	localparam int IRQ_SYNC_STAGES = 2;

	typedef logic [N_IRQ-1:0] irq_vec_t;

endpackage

`default_nettype wire

// ==== rtl/apb_region_decode.sv ====
// APB region decoder
// Maps an AHB address onto one of the 64 KB APB regions and flags
// whether the address lands in a populated region

`timescale 1ns/1ns
`default_nettype none

module apb_region_decode (
	input  periph_bus_pkg::sys_addr_t   haddr_i,  // AHB address phase address
	output periph_bus_pkg::apb_region_t region_o, // Region index
	output logic                        hit_o     // Populated region
);

	import periph_bus_pkg::*;

	logic base_match; // Upper bits equal the APB window

	// Everything above the region index must match the base
	assign base_match = (haddr_i[ADDR_W-1:APB_REGION_LOG2+$bits(apb_region_t)] ==
		APB_BASE[ADDR_W-1:APB_REGION_LOG2+$bits(apb_region_t)]);

	// Region index sits right above the 64 KB offset (bits 17:16)
	assign region_o = haddr_i[APB_REGION_LOG2 +: $bits(apb_region_t)];

	// Index 3 is a hole in the map
	always_comb begin
		hit_o = 1'b0;
		if (base_match && (region_o < N_APB_REGIONS)) begin
			hit_o = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/apb_xfer_reg.sv ====
// APB transfer register
// Captures the accepted AHB address phase and the following write data,
// and presents them to the APB regions with psel and penable

`timescale 1ns/1ns
`default_nettype none

module apb_xfer_reg (
	input  logic                        sys_root_clk,
	input  logic                        reset_i,
	input  logic                        accept_i,     // Address phase taken
	input  logic                        wdata_load_i, // hwdata valid
	input  logic                        setup_i,
	input  logic                        access_i,
	input  periph_bus_pkg::sys_addr_t   haddr_i,
	input  logic                        hwrite_i,
	input  periph_bus_pkg::sys_data_t   hwdata_i,
	input  periph_bus_pkg::apb_region_t region_i,
	input  logic                        hit_i,
	input  periph_bus_pkg::apb_sel_t    pready_i,
	output periph_bus_pkg::apb_sel_t    psel_o,
	output logic                        penable_o,
	output periph_bus_pkg::sys_addr_t   paddr_o,
	output logic                        pwrite_o,
	output periph_bus_pkg::sys_data_t   pwdata_o,
	output periph_bus_pkg::apb_region_t region_o,
	output logic                        hit_o,
	output logic                        pready_sel_o
);

	import periph_bus_pkg::*;

	// Address phase fields
	always_ff @(posedge sys_root_clk) begin
		if (accept_i) begin
			paddr_o  <= haddr_i;
			pwrite_o <= hwrite_i;
			region_o <= region_i;
		end
		if (wdata_load_i) begin
			pwdata_o <= hwdata_i; // One cycle after accept
		end
	end

	// Hit flag decides hrdata gating
	always_ff @(posedge sys_root_clk) begin
		if (reset_i) begin
			hit_o <= 1'b0;
		end else if (accept_i) begin
			hit_o <= hit_i;
		end
	end

	// One-hot select and ready mux from the stored region
	always_comb begin
		psel_o       = '0;
		pready_sel_o = 1'b0;
		for (int i = 0; i < N_APB_REGIONS; i++) begin
			if (region_o == apb_region_t'(i)) begin
				psel_o[i]    = setup_i || access_i;
				pready_sel_o = pready_i[i];
			end
		end
	end

	assign penable_o = access_i; // Second APB phase only

endmodule

`default_nettype wire

// ==== rtl/apb_rdata_capture.sv ====
// APB read data capture
// Registers the addressed region's prdata when a read completes and
// returns zero on AHB for unmapped transfers

`timescale 1ns/1ns
`default_nettype none

module apb_rdata_capture (
	input  logic                        sys_root_clk,
	input  logic                        reset_i,
	input  logic                        done_i,   // Access ends this edge
	input  logic                        write_i,  // Stored direction
	input  logic                        hit_i,    // Stored hit
	input  periph_bus_pkg::apb_region_t region_i, // Stored region
	input  periph_bus_pkg::sys_data_t [periph_bus_pkg::N_APB_REGIONS-1:0] prdata_i,
	output periph_bus_pkg::sys_data_t   hrdata_o
);

	import periph_bus_pkg::*;

	sys_data_t prdata_sel; // Word of the addressed region
	sys_data_t rdata_q;

	always_comb begin
		prdata_sel = '0;
		for (int i = 0; i < N_APB_REGIONS; i++) begin
			if (region_i == apb_region_t'(i)) begin
				prdata_sel = prdata_i[i];
			end
		end
	end

	// Writes leave the last read word in place
	always_ff @(posedge sys_root_clk) begin
		if (reset_i) begin
			rdata_q <= '0;
		end else if (done_i && !write_i) begin
			rdata_q <= prdata_sel;
		end
	end

	// Unmapped data phase reads back zero
	assign hrdata_o = hit_i ? rdata_q : '0;

endmodule

`default_nettype wire

// ==== rtl/ahb_apb_bridge_ctrl.sv ====
// AHB-lite to APB bridge
// FSM that accepts AHB transfers, holds the master through the APB setup
// and access phases and completes unmapped transfers at once

`timescale 1ns/1ns
`default_nettype none

module ahb_apb_bridge_ctrl (
	input  logic                                          sys_root_clk,
	input  logic                                          reset_i,
	// AHB-lite slave side
	input  logic                                          hsel_i,
	input  periph_bus_pkg::sys_addr_t                     haddr_i,
	input  periph_bus_pkg::htrans_e                       htrans_i,
	input  logic                                          hwrite_i,
	input  periph_bus_pkg::sys_data_t                     hwdata_i,
	input  logic                                          hready_i,
	output logic                                          hreadyout_o,
	output periph_bus_pkg::sys_data_t                     hrdata_o,
	// APB master side, shared by all regions
	output periph_bus_pkg::apb_sel_t                      psel_o,
	output logic                                          penable_o,
	output periph_bus_pkg::sys_addr_t                     paddr_o,
	output logic                                          pwrite_o,
	output periph_bus_pkg::sys_data_t                     pwdata_o,
	input  periph_bus_pkg::sys_data_t [periph_bus_pkg::N_APB_REGIONS-1:0] prdata_i,
	input  periph_bus_pkg::apb_sel_t                      pready_i,
	// Sequencing strobes
	output logic                                          accept_o,
	output logic                                          wdata_load_o,
	output logic                                          setup_o,
	output logic                                          access_o,
	output logic                                          done_o
);

	import periph_bus_pkg::*;

	bridge_state_e state_q;
	bridge_state_e state_d;

	apb_region_t dec_region;  // Live decode of haddr
	logic        hit;         // Live hit of haddr
	apb_region_t xfer_region; // Region of the transfer in flight
	logic        xfer_hit;    // Transfer in flight is mapped
	logic        pready_sel;  // pready of the addressed region

	//==========================================================================
	// Control
	//==========================================================================

	assign hreadyout_o = (state_q == ST_IDLE); // Low while APB is busy

	// Only NONSEQ and SEQ carry a transfer
	assign accept_o = hsel_i && hready_i && hreadyout_o &&
		((htrans_i == NONSEQ) || (htrans_i == SEQ));

	assign wdata_load_o = (state_q == ST_LATCH);  // hwdata valid now
	assign setup_o      = (state_q == ST_SETUP);
	assign access_o     = (state_q == ST_ACCESS);
	assign done_o       = access_o && pready_sel; // Last access cycle

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (accept_o && hit) begin
					state_d = ST_LATCH; // Unmapped stays here
				end
			end
			ST_LATCH:  state_d = ST_SETUP;
			ST_SETUP:  state_d = ST_ACCESS;
			ST_ACCESS: begin
				if (pready_sel) begin
					state_d = ST_IDLE; // Slave finished
				end
			end
			default:   state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge sys_root_clk) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	//==========================================================================
	// Datapath
	//==========================================================================

	apb_region_decode u_apb_region_decode (
		.haddr_i  (haddr_i),
		.region_o (dec_region),
		.hit_o    (hit)
	);

	apb_xfer_reg u_apb_xfer_reg (
		.sys_root_clk (sys_root_clk),
		.reset_i      (reset_i),
		.accept_i     (accept_o),
		.wdata_load_i (wdata_load_o),
		.setup_i      (setup_o),
		.access_i     (access_o),
		.haddr_i      (haddr_i),
		.hwrite_i     (hwrite_i),
		.hwdata_i     (hwdata_i),
		.region_i     (dec_region),
		.hit_i        (hit),
		.pready_i     (pready_i),
		.psel_o       (psel_o),
		.penable_o    (penable_o),
		.paddr_o      (paddr_o),
		.pwrite_o     (pwrite_o),
		.pwdata_o     (pwdata_o),
		.region_o     (xfer_region),
		.hit_o        (xfer_hit),
		.pready_sel_o (pready_sel)
	);

	apb_rdata_capture u_apb_rdata_capture (
		.sys_root_clk (sys_root_clk),
		.reset_i      (reset_i),
		.done_i       (done_o),
		.write_i      (pwrite_o),    // Stored direction
		.hit_i        (xfer_hit),
		.region_i     (xfer_region),
		.prdata_i     (prdata_i),
		.hrdata_o     (hrdata_o)
	);

endmodule

`default_nettype wire

// ==== rtl/irq_sync_collect.sv ====
// Interrupt collector
// Passes the synchronous lines straight through, resynchronizes the
// asynchronous lines and packs both into one vector

`timescale 1ns/1ns
`default_nettype none

module irq_sync_collect (
	input  logic                                    sys_root_clk,
	input  logic                                    reset_i,
	input  logic [periph_bus_pkg::N_SYNC_IRQ-1:0]  sync_irq_i,  // sys clock domain
	input  logic [periph_bus_pkg::N_ASYNC_IRQ-1:0] async_irq_i, // Foreign domains
	output periph_bus_pkg::irq_vec_t                irq_o
);

	import periph_bus_pkg::*;

	logic [N_ASYNC_IRQ-1:0] sync_ff [IRQ_SYNC_STAGES]; // Synchronizer chain

	//==========================================================================
	// Asynchronous lines
	//==========================================================================

	always_ff @(posedge sys_root_clk) begin
		if (reset_i) begin
			for (int s = 0; s < IRQ_SYNC_STAGES; s++) begin
				sync_ff[s] <= '0;
			end
		end else begin
			sync_ff[0] <= async_irq_i; // First stage may go metastable
			for (int s = 1; s < IRQ_SYNC_STAGES; s++) begin
				sync_ff[s] <= sync_ff[s-1];
			end
		end
	end

	//==========================================================================
	// Vector packing
	//==========================================================================

	// Sync lines low, resynced lines above
	assign irq_o = {sync_ff[IRQ_SYNC_STAGES-1], sync_irq_i};

endmodule

`default_nettype wire

// ==== rtl/periph_subsys_top.sv ====
// Peripheral subsystem top
// AHB-lite slave port bridged onto three APB regions, plus the
// interrupt collector for the peripheral interrupt lines

`timescale 1ns/1ns
`default_nettype none

module periph_subsys_top (
	input  logic                                    sys_root_clk,
	input  logic                                    reset_i,
	// AHB-lite slave port
	input  logic                                    hsel_i,
	input  periph_bus_pkg::sys_addr_t               haddr_i,
	input  periph_bus_pkg::htrans_e                 htrans_i,
	input  logic                                    hwrite_i,
	input  periph_bus_pkg::sys_data_t               hwdata_i,
	input  logic                                    hready_i,
	output logic                                    hreadyout_o,
	output periph_bus_pkg::sys_data_t               hrdata_o,
	// APB regions 0x4000_0000 / 0x4001_0000 / 0x4002_0000
	output periph_bus_pkg::apb_sel_t                psel_o,
	output logic                                    penable_o,
	output periph_bus_pkg::sys_addr_t               paddr_o,
	output logic                                    pwrite_o,
	output periph_bus_pkg::sys_data_t               pwdata_o,
	input  periph_bus_pkg::sys_data_t [periph_bus_pkg::N_APB_REGIONS-1:0] prdata_i,
	input  periph_bus_pkg::apb_sel_t                pready_i,
	// Interrupts
	input  logic [periph_bus_pkg::N_SYNC_IRQ-1:0]  sync_irq_i,
	input  logic [periph_bus_pkg::N_ASYNC_IRQ-1:0] async_irq_i,
	output periph_bus_pkg::irq_vec_t                irq_o
);

	//==========================================================================
	// AHB to APB bridge
	//==========================================================================

	ahb_apb_bridge_ctrl u_ahb_apb_bridge_ctrl (
		.sys_root_clk (sys_root_clk),
		.reset_i      (reset_i),
		.hsel_i       (hsel_i),
		.haddr_i      (haddr_i),
		.htrans_i     (htrans_i),
		.hwrite_i     (hwrite_i),
		.hwdata_i     (hwdata_i),
		.hready_i     (hready_i),
		.hreadyout_o  (hreadyout_o),
		.hrdata_o     (hrdata_o),
		.psel_o       (psel_o),
		.penable_o    (penable_o),
		.paddr_o      (paddr_o),
		.pwrite_o     (pwrite_o),
		.pwdata_o     (pwdata_o),
		.prdata_i     (prdata_i),
		.pready_i     (pready_i),
		.accept_o     (),          // Strobes kept for observation
		.wdata_load_o (),
		.setup_o      (),
		.access_o     (),
		.done_o       ()
	);

	//==========================================================================
	// Interrupt collector
	//==========================================================================

	irq_sync_collect u_irq_sync_collect (
		.sys_root_clk (sys_root_clk),
		.reset_i      (reset_i),
		.sync_irq_i   (sync_irq_i),
		.async_irq_i  (async_irq_i),
		.irq_o        (irq_o)
	);

endmodule

`default_nettype wire

// ==== verif/periph_subsys_assert.sv ====
// Bridge protocol assertions
// Bound into the AHB to APB bridge FSM, checks the APB select and
// enable rules and the ready level coming out of reset

`timescale 1ns/1ns
`default_nettype none

module periph_subsys_assert (
	input logic                      sys_root_clk,
	input logic                      reset_i,
	input periph_bus_pkg::apb_sel_t  psel_i,
	input logic                      penable_i,
	input periph_bus_pkg::sys_addr_t paddr_i,
	input logic                      access_i,
	input logic                      hreadyout_i
);

	int fail_cnt = 0; // Failed assertion count

	a_penable_psel: assert property (@(posedge sys_root_clk) disable iff (reset_i)
		penable_i |-> (psel_i != '0))
		else begin
			fail_cnt++;
			$error("penable high while psel is zero");
		end

	a_psel_onehot: assert property (@(posedge sys_root_clk) disable iff (reset_i)
		$onehot0(psel_i))
		else begin
			fail_cnt++;
			$error("psel has more than one bit set");
		end

	// Address held from setup through every wait cycle
	a_paddr_stable: assert property (@(posedge sys_root_clk) disable iff (reset_i)
		access_i |-> $stable(paddr_i))
		else begin
			fail_cnt++;
			$error("paddr changed during the access phase");
		end

	a_ready_after_reset: assert property (@(posedge sys_root_clk)
		$fell(reset_i) |-> hreadyout_i)
		else begin
			fail_cnt++;
			$error("hreadyout low right after reset");
		end

endmodule

bind ahb_apb_bridge_ctrl periph_subsys_assert u_bridge_assert (
	.sys_root_clk (sys_root_clk),
	.reset_i      (reset_i),
	.psel_i       (psel_o),
	.penable_i    (penable_o),
	.paddr_i      (paddr_o),
	.access_i     (access_o),
	.hreadyout_i  (hreadyout_o)
);

`default_nettype wire

// ==== verif/tb_periph_subsys.sv ====
// Peripheral subsystem testbench
// Directed AHB-lite master tasks against three APB register-file slaves,
// interrupt collector checks and a run watchdog

`timescale 1ns/1ns
`default_nettype none

module tb_periph_subsys;

	import periph_bus_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int SEED        = 32'h7e919c34;
	localparam int N_XFERS     = 32;   // Bus transfers over all tests
	localparam int MAX_WAIT    = 5;    // Longest random pready delay
	localparam int WATCHDOG_NS = (N_XFERS * (4 + MAX_WAIT) + 100) * CLK_PERIOD;
	localparam int SLAVE_WORDS = 16;
	localparam int MAX_BATCH   = 8;

	logic                              sys_root_clk = 1'b0;
	logic                              reset;
	logic                              hsel;
	sys_addr_t                         haddr;
	htrans_e                           htrans;
	logic                              hwrite;
	sys_data_t                         hwdata;
	logic                              hready;
	logic                              hreadyout;
	sys_data_t                         hrdata;
	apb_sel_t                          psel;
	logic                              penable;
	sys_addr_t                         paddr;
	logic                              pwrite;
	sys_data_t                         pwdata;
	sys_data_t [N_APB_REGIONS-1:0]     prdata;
	apb_sel_t                          pready;
	logic [N_SYNC_IRQ-1:0]             sync_irq;
	logic [N_ASYNC_IRQ-1:0]            async_irq;
	irq_vec_t                          irq;

	integer    seed;
	int        n_checks = 0;
	int        n_err    = 0;
	logic      rand_wait;                                  // Random pready delays on
	logic      psel_seen;                                  // Any psel during a batch
	int        setup_count;                                // APB setups in a batch
	int        wait_log  [64];                             // Delay picked per setup
	int        wait_cnt  [N_APB_REGIONS];
	sys_data_t slave_mem [N_APB_REGIONS][SLAVE_WORDS];
	sys_data_t exp_mem   [N_APB_REGIONS][SLAVE_WORDS];     // Reference contents

	// Transfer batch, in bus order
	sys_addr_t x_addr   [MAX_BATCH];
	logic      x_write  [MAX_BATCH];
	logic      x_mapped [MAX_BATCH];
	sys_data_t x_wdata  [MAX_BATCH];
	sys_data_t x_rdata  [MAX_BATCH];
	sys_data_t x_exp    [MAX_BATCH];
	int        x_low    [MAX_BATCH];                       // hreadyout low cycles

	always #(CLK_PERIOD / 2) sys_root_clk = ~sys_root_clk;

	periph_subsys_top DUT (
		.sys_root_clk (sys_root_clk),
		.reset_i      (reset),
		.hsel_i       (hsel),
		.haddr_i      (haddr),
		.htrans_i     (htrans),
		.hwrite_i     (hwrite),
		.hwdata_i     (hwdata),
		.hready_i     (hready),
		.hreadyout_o  (hreadyout),
		.hrdata_o     (hrdata),
		.psel_o       (psel),
		.penable_o    (penable),
		.paddr_o      (paddr),
		.pwrite_o     (pwrite),
		.pwdata_o     (pwdata),
		.prdata_i     (prdata),
		.pready_i     (pready),
		.sync_irq_i   (sync_irq),
		.async_irq_i  (async_irq),
		.irq_o        (irq)
	);

	//==========================================================================
	// APB slave models
	//==========================================================================

	always @(posedge sys_root_clk) begin : apb_slaves
		int w;
		for (int r = 0; r < N_APB_REGIONS; r++) begin
			if (psel[r] && !penable) begin // Setup phase
				w = rand_wait ? $unsigned($random(seed)) % (MAX_WAIT + 1) : 0;
				wait_log[setup_count] = w;
				setup_count = setup_count + 1;
				wait_cnt[r] <= w;
				pready[r]   <= (w == 0);
				prdata[r]   <= slave_mem[r][paddr[5:2]];
			end else if (psel[r] && penable) begin
				if (pready[r]) begin
					if (pwrite) begin
						slave_mem[r][paddr[5:2]] <= pwdata;
					end
					pready[r] <= 1'b0; // Access done
				end else begin
					wait_cnt[r] <= wait_cnt[r] - 1;
					pready[r]   <= (wait_cnt[r] == 1);
				end
			end
		end
	end

	//==========================================================================
	// Helpers
	//==========================================================================

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_err++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic sys_addr_t word_addr(input int r, input int k);
		return APB_BASE + (sys_addr_t'(r) << APB_REGION_LOG2) + sys_addr_t'(k * 4);
	endfunction

	// Power-up contents, unique per address
	function automatic sys_data_t fill_word(input sys_addr_t a);
		return {a[15:0], a[31:16]} ^ 32'h3C5A_96E1;
	endfunction

	// Region 3 is the hole in the map
	task automatic queue_xfer(input int i, input int r, input int k, input logic wr,
		input sys_data_t data);
		x_addr[i]   = word_addr(r, k);
		x_write[i]  = wr;
		x_wdata[i]  = data;
		x_mapped[i] = (r < N_APB_REGIONS);
		x_exp[i]    = '0;
		if (x_mapped[i]) begin
			if (wr) begin
				exp_mem[r][k] = data;
			end else begin
				x_exp[i] = exp_mem[r][k];
			end
		end
	endtask

	task automatic drive_addr_phase(input int i);
		hsel   <= 1'b1;
		haddr  <= x_addr[i];
		htrans <= NONSEQ;
		hwrite <= x_write[i];
	endtask

	// AHB master: next address goes out while the previous data phase runs
	task automatic run_transfers(input int n);
		int next;
		int cur;
		int low;
		next        = 0;
		cur         = -1;
		low         = 0;
		setup_count = 0;
		@(posedge sys_root_clk);
		drive_addr_phase(0);
		while (next < n || cur >= 0) begin
			@(negedge sys_root_clk);
			if (psel != '0) begin
				psel_seen = 1'b1;
				check_value("paddr during APB phases", paddr, x_addr[cur]);
				check_value("pwrite during APB phases", pwrite, x_write[cur]);
			end
			if (!hreadyout) begin
				low++;
			end else begin
				if (cur >= 0) begin
					x_rdata[cur] = hrdata;
					x_low[cur]   = low;
				end
				@(posedge sys_root_clk); // Ready edge
				low = 0;
				if (next < n) begin
					hwdata <= x_wdata[next];
					cur = next;
					next++;
				end else begin
					cur = -1;
				end
				if (next < n) begin
					drive_addr_phase(next);
				end else begin
					hsel   <= 1'b0;
					htrans <= IDLE;
				end
			end
		end
	endtask

	task automatic check_batch(input int n);
		int j;
		j = 0;
		for (int i = 0; i < n; i++) begin
			if (!x_write[i]) begin
				check_value($sformatf("hrdata of transfer %0d", i), x_rdata[i], x_exp[i]);
			end
			if (x_mapped[i]) begin
				check_value($sformatf("ready low cycles of transfer %0d", i), x_low[i],
					3 + wait_log[j]); // LATCH, SETUP, ACCESS plus waits
				j++;
			end else begin
				check_value($sformatf("ready low cycles of transfer %0d", i), x_low[i], 0);
			end
		end
	endtask

	task automatic single_xfer(input int r, input int k, input logic wr,
		input sys_data_t data);
		queue_xfer(0, r, k, wr, data);
		run_transfers(1);
		check_batch(1);
	endtask

	task automatic report_test(input string name, input int e0);
		$display("%s: %0d errors", name, n_err - e0);
	endtask

	//==========================================================================
	// Tests
	//==========================================================================

	task automatic test_reset_values();
		int e0;
		e0 = n_err;
		@(negedge sys_root_clk);
		check_value("hreadyout after reset", hreadyout, 1'b1);
		check_value("psel after reset", psel, '0);
		check_value("penable after reset", penable, 1'b0);
		check_value("hrdata after reset", hrdata, '0);
		check_value("irq after reset", irq, '0);
		report_test("reset values", e0);
	endtask

	task automatic test_region_map();
		int e0;
		e0 = n_err;
		rand_wait = 1'b0;
		for (int r = 0; r < N_APB_REGIONS; r++) begin // Same offset everywhere
			single_xfer(r, 2, 1'b1, 32'h1000_0000 * (r + 1) + 32'h00AB_CD00 + r);
		end
		for (int r = 0; r < N_APB_REGIONS; r++) begin // Read back once all are written
			single_xfer(r, 2, 1'b0, '0);
		end
		report_test("region map", e0);
	endtask

	task automatic test_random_waits();
		int e0;
		int r;
		int k;
		e0 = n_err;
		rand_wait = 1'b1;
		for (int t = 0; t < 8; t++) begin
			r = $unsigned($random(seed)) % N_APB_REGIONS;
			k = $unsigned($random(seed)) % SLAVE_WORDS;
			single_xfer(r, k, 1'b1, $random(seed));
			single_xfer(r, k, 1'b0, '0);
		end
		report_test("random pready waits", e0);
	endtask

	task automatic test_unmapped();
		int e0;
		e0 = n_err;
		psel_seen = 1'b0;
		single_xfer(3, 4, 1'b1, 32'hDEAD_BEEF);
		single_xfer(3, 4, 1'b0, '0);
		x_addr[0]   = 32'h5000_0000; // Outside the APB window
		x_write[0]  = 1'b0;
		x_mapped[0] = 1'b0;
		x_exp[0]    = '0;
		run_transfers(1);
		check_batch(1);
		check_value("psel during unmapped transfers", psel_seen, 1'b0);
		check_value("APB setups for unmapped transfers", setup_count, 0);
		report_test("unmapped access", e0);
	endtask

	task automatic test_back_to_back();
		int e0;
		e0 = n_err;
		rand_wait = 1'b1;
		queue_xfer(0, 0, 7, 1'b1, 32'hCAFE_0007);
		queue_xfer(1, 1, 7, 1'b1, 32'hCAFE_1007);
		queue_xfer(2, 0, 7, 1'b0, '0);
		queue_xfer(3, 3, 1, 1'b0, '0);            // Unmapped in the middle
		queue_xfer(4, 2, 9, 1'b1, 32'hCAFE_2009);
		queue_xfer(5, 1, 7, 1'b0, '0);
		queue_xfer(6, 2, 9, 1'b0, '0);
		run_transfers(7);
		check_batch(7);
		report_test("back-to-back transfers", e0);
	endtask

	task automatic test_irq();
		int e0;
		logic [N_ASYNC_IRQ-1:0] old_async;
		logic [N_ASYNC_IRQ-1:0] new_async;
		e0 = n_err;
		for (int pass = 0; pass < 2; pass++) begin
			old_async = async_irq;
			new_async = (pass == 0) ? 16'hC0DE : 16'h0F0F;
			@(posedge sys_root_clk);
			sync_irq  <= (pass == 0) ? 8'h5A : 8'h81;
			async_irq <= new_async;
			for (int c = 0; c < 3; c++) begin
				@(negedge sys_root_clk);
				check_value("sync irq bits", irq[N_SYNC_IRQ-1:0], (pass == 0) ? 8'h5A : 8'h81);
				check_value($sformatf("async irq bits %0d cycles after change", c),
					irq[N_IRQ-1:N_SYNC_IRQ], (c == 2) ? new_async : old_async);
			end
		end
		report_test("interrupt collector", e0);
	endtask

	//==========================================================================
	// Sequence and watchdog
	//==========================================================================

	initial begin
		seed      = SEED;
		rand_wait = 1'b0;
		psel_seen = 1'b0;
		reset     <= 1'b1;
		hsel      <= 1'b0;
		haddr     <= '0;
		htrans    <= IDLE;
		hwrite    <= 1'b0;
		hwdata    <= '0;
		hready    <= 1'b1; // Single slave on the bus
		prdata    <= '0;
		pready    <= '0;
		sync_irq  <= '0;
		async_irq <= '0;
		for (int r = 0; r < N_APB_REGIONS; r++) begin
			wait_cnt[r] = 0;
			for (int k = 0; k < SLAVE_WORDS; k++) begin
				slave_mem[r][k] = fill_word(word_addr(r, k));
				exp_mem[r][k]   = fill_word(word_addr(r, k));
			end
		end
		repeat (8) @(posedge sys_root_clk);
		reset <= 1'b0;
		test_reset_values();
		test_region_map();
		test_random_waits();
		test_unmapped();
		test_back_to_back();
		test_irq();
		n_err = n_err + DUT.u_ahb_apb_bridge_ctrl.u_bridge_assert.fail_cnt;
		$display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_err,
			DUT.u_ahb_apb_bridge_ctrl.u_bridge_assert.fail_cnt);
		if (n_err == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/periph_bus_pkg.sv
rtl/apb_region_decode.sv
rtl/apb_xfer_reg.sv
rtl/apb_rdata_capture.sv
rtl/ahb_apb_bridge_ctrl.sv
rtl/irq_sync_collect.sv
rtl/periph_subsys_top.sv
verif/periph_subsys_assert.sv
verif/tb_periph_subsys.sv

// ==== Bender.yml ====
package:
  name: periph_subsys

sources:
  - files:
      - rtl/periph_bus_pkg.sv
      - rtl/apb_region_decode.sv
      - rtl/apb_xfer_reg.sv
      - rtl/apb_rdata_capture.sv
      - rtl/ahb_apb_bridge_ctrl.sv
      - rtl/irq_sync_collect.sv
      - rtl/periph_subsys_top.sv
  - target: simulation
    files:
      - verif/periph_subsys_assert.sv
      - verif/tb_periph_subsys.sv
